// ==== source/decode_pkg.sv ====
// RV32 decode package
// Shared word types, opcode and funct7 constants, ALU/LSU operation codes
package decode_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [3:0]  lsu_op_t;
  typedef logic [2:0]  imm_fmt_t;

  // Major opcodes in instr[6:0]
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;  // SUB, SRA, SRAI
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam alu_op_t ALU_ADD    = 5'd0;
  localparam alu_op_t ALU_SUB    = 5'd1;
  localparam alu_op_t ALU_AND    = 5'd2;
  localparam alu_op_t ALU_OR     = 5'd3;
  localparam alu_op_t ALU_XOR    = 5'd4;
  localparam alu_op_t ALU_SLL    = 5'd5;
  localparam alu_op_t ALU_SRL    = 5'd6;
  localparam alu_op_t ALU_SRA    = 5'd7;
  localparam alu_op_t ALU_SLT    = 5'd8;
  localparam alu_op_t ALU_SLTU   = 5'd9;
  localparam alu_op_t ALU_MUL    = 5'd10;
  localparam alu_op_t ALU_MULH   = 5'd11;
  localparam alu_op_t ALU_MULHSU = 5'd12;
  localparam alu_op_t ALU_MULHU  = 5'd13;
  localparam alu_op_t ALU_DIV    = 5'd14;
  localparam alu_op_t ALU_DIVU   = 5'd15;
  localparam alu_op_t ALU_REM    = 5'd16;
  localparam alu_op_t ALU_REMU   = 5'd17;

  // No memory access
  localparam lsu_op_t LSU_NONE = 4'd0;
  localparam lsu_op_t LSU_LB   = 4'd1;
  localparam lsu_op_t LSU_LBU  = 4'd2;
  localparam lsu_op_t LSU_LH   = 4'd3;
  localparam lsu_op_t LSU_LHU  = 4'd4;
  localparam lsu_op_t LSU_LW   = 4'd5;
  localparam lsu_op_t LSU_SB   = 4'd6;
  localparam lsu_op_t LSU_SH   = 4'd7;
  localparam lsu_op_t LSU_SW   = 4'd8;

  localparam imm_fmt_t IMM_NONE  = 3'd0;  // Immediate reads as zero
  localparam imm_fmt_t IMM_I     = 3'd1;
  localparam imm_fmt_t IMM_S     = 3'd2;
  localparam imm_fmt_t IMM_B     = 3'd3;
  localparam imm_fmt_t IMM_U     = 3'd4;
  localparam imm_fmt_t IMM_J     = 3'd5;
  localparam imm_fmt_t IMM_SHAMT = 3'd6;  // Zero-extended instr[24:20]

endpackage

// ==== source/ctl_decode.sv ====
// Control decode for RV32IM
// Maps opcode, funct3 and funct7 to unit flags, operation codes and immediate format
module ctl_decode import decode_pkg::*; (
  input  instr_t   instr,
  output alu_op_t  alu_op,
  output lsu_op_t  lsu_op,
  output imm_fmt_t imm_fmt,
  output logic     rd_en,
  output logic     use_imm,
  output logic     ctl_alu,
  output logic     ctl_lsu,
  output logic     ctl_lui,
  output logic     ctl_auipc,
  output logic     ctl_br,
  output logic     ctl_jal,
  output logic     illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    alu_op    = ALU_ADD;
    lsu_op    = LSU_NONE;
    imm_fmt   = IMM_NONE;
    rd_en     = 1'b0;
    use_imm   = 1'b0;
    ctl_alu   = 1'b0;
    ctl_lsu   = 1'b0;
    ctl_lui   = 1'b0;
    ctl_auipc = 1'b0;
    ctl_br    = 1'b0;
    ctl_jal   = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      OPC_JAL: begin
        {ctl_alu, ctl_jal, rd_en, use_imm} = 4'b1111;
        imm_fmt = IMM_J;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          {ctl_alu, ctl_jal, rd_en, use_imm} = 4'b1111;
          imm_fmt = IMM_I;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin  // No branch here
          illegal = 1'b1;
        end else begin
          ctl_br  = 1'b1;
          use_imm = 1'b1;
          imm_fmt = IMM_B;
        end
      end
      OPC_LUI: begin
        {ctl_alu, ctl_lui, rd_en, use_imm} = 4'b1111;
        imm_fmt = IMM_U;
      end
      OPC_AUIPC: begin
        {ctl_alu, ctl_auipc, rd_en, use_imm} = 4'b1111;
        imm_fmt = IMM_U;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  lsu_op = LSU_LB;
          3'b001:  lsu_op = LSU_LH;
          3'b010:  lsu_op = LSU_LW;
          3'b100:  lsu_op = LSU_LBU;
          3'b101:  lsu_op = LSU_LHU;
          default: illegal = 1'b1;
        endcase
        if (!illegal) begin
          {ctl_lsu, rd_en} = 2'b11;
          imm_fmt = IMM_I;
        end
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  lsu_op = LSU_SB;
          3'b001:  lsu_op = LSU_SH;
          3'b010:  lsu_op = LSU_SW;
          default: illegal = 1'b1;
        endcase
        if (!illegal) begin
          ctl_lsu = 1'b1;
          imm_fmt = IMM_S;
        end
      end
      OPC_OP_IMM: begin
        imm_fmt = IMM_I;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            imm_fmt = IMM_SHAMT;
            if (funct7 == F7_BASE) alu_op = ALU_SLL;
            else illegal = 1'b1;
          end
          default: begin  // SRLI or SRAI
            imm_fmt = IMM_SHAMT;
            if (funct7 == F7_BASE) alu_op = ALU_SRL;
            else if (funct7 == F7_ALT) alu_op = ALU_SRA;
            else illegal = 1'b1;
          end
        endcase
        if (illegal) imm_fmt = IMM_NONE;
        else {ctl_alu, rd_en, use_imm} = 3'b111;
      end
      OPC_OP: begin
        case (funct7)
          F7_BASE: begin
            case (funct3)
              3'b000:  alu_op = ALU_ADD;
              3'b001:  alu_op = ALU_SLL;
              3'b010:  alu_op = ALU_SLT;
              3'b011:  alu_op = ALU_SLTU;
              3'b100:  alu_op = ALU_XOR;
              3'b101:  alu_op = ALU_SRL;
              3'b110:  alu_op = ALU_OR;
              default: alu_op = ALU_AND;
            endcase
          end
          F7_ALT: begin
            if (funct3 == 3'b000) alu_op = ALU_SUB;
            else if (funct3 == 3'b101) alu_op = ALU_SRA;
            else illegal = 1'b1;
          end
          F7_MULDIV: alu_op = ALU_MUL + alu_op_t'(funct3);  // MUL..REMU in funct3 order
          default: illegal = 1'b1;
        endcase
        if (!illegal) {ctl_alu, rd_en} = 2'b11;
      end
      OPC_MISC_MEM: begin
        // FENCE and FENCE.I become an add with nothing written back
        if (funct3 == 3'b000 || funct3 == 3'b001) {ctl_alu, use_imm} = 2'b11;
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;  // Includes SYSTEM
    endcase
  end

  // An illegal instruction must not reach any execution unit
  always_comb begin
    assert (!(illegal && (rd_en || ctl_alu || ctl_lsu)))
      else $error("ctl_decode: illegal with rd_en/alu/lsu set, instr %h", instr);
  end

endmodule

// ==== source/imm_gen.sv ====
// Immediate generator
// Builds the RV32 immediate layouts and picks one by format code
module imm_gen import decode_pkg::*; (
  input  instr_t   instr,
  input  imm_fmt_t imm_fmt,
  output data_t    imm
);

  data_t imm_i;
  data_t imm_s;
  data_t imm_b;
  data_t imm_u;
  data_t imm_j;
  data_t imm_shamt;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  // Branch offset with bit 0 implied zero
  assign imm_b = {
    {20{instr[31]}},
    instr[7],
    instr[30:25],
    instr[11:8],
    1'b0
  };

  assign imm_u = {instr[31:12], 12'b0};

  assign imm_j = {
    {12{instr[31]}},
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  assign imm_shamt = {27'b0, instr[24:20]};

  always_comb begin
    case (imm_fmt)
      IMM_I:     imm = imm_i;
      IMM_S:     imm = imm_s;
      IMM_B:     imm = imm_b;
      IMM_U:     imm = imm_u;
      IMM_J:     imm = imm_j;
      IMM_SHAMT: imm = imm_shamt;
      default:   imm = '0;  // IMM_NONE and unused codes
    endcase
  end

endmodule

// ==== source/decode_stage.sv ====
// Decode output stage
// One-entry valid/ready register holding the decoded results of one instruction
module decode_stage import decode_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  reg_addr_t rd_addr_in,
  input  reg_addr_t rs1_addr_in,
  input  reg_addr_t rs2_addr_in,
  input  data_t     imm_in,
  input  alu_op_t   alu_op_in,
  input  lsu_op_t   lsu_op_in,
  input  logic      rd_en_in,
  input  logic      use_imm_in,
  input  logic      ctl_alu_in,
  input  logic      ctl_lsu_in,
  input  logic      ctl_lui_in,
  input  logic      ctl_auipc_in,
  input  logic      ctl_br_in,
  input  logic      ctl_jal_in,
  input  logic      illegal_in,
  output logic      out_valid,
  input  logic      out_ready,
  output reg_addr_t rd_addr,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output data_t     imm,
  output alu_op_t   alu_op,
  output lsu_op_t   lsu_op,
  output logic      rd_en,
  output logic      use_imm,
  output logic      ctl_alu,
  output logic      ctl_lsu,
  output logic      ctl_lui,
  output logic      ctl_auipc,
  output logic      ctl_br,
  output logic      ctl_jal,
  output logic      illegal
);

  logic accept;

  // Empty, or being drained this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_addr  <= rd_addr_in;
      rs1_addr <= rs1_addr_in;
      rs2_addr <= rs2_addr_in;
      imm      <= imm_in;
      alu_op   <= alu_op_in;
      lsu_op   <= lsu_op_in;
      {rd_en, use_imm, ctl_alu, ctl_lsu} <= {rd_en_in, use_imm_in, ctl_alu_in, ctl_lsu_in};
      {ctl_lui, ctl_auipc, ctl_br, ctl_jal} <= {ctl_lui_in, ctl_auipc_in, ctl_br_in, ctl_jal_in};
      illegal  <= illegal_in;
    end
  end

  // Stalled result must survive until consumed
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable({
      rd_addr, rs1_addr, rs2_addr, imm, alu_op, lsu_op, rd_en, use_imm,
      ctl_alu, ctl_lsu, ctl_lui, ctl_auipc, ctl_br, ctl_jal, illegal
    })
  ) else $error("decode_stage: held result changed under back-pressure");

endmodule

// ==== source/riscv_decoder.sv ====
// RV32IM instruction decoder
// Field extraction, control decode and immediate generation behind one register stage
module riscv_decoder import decode_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  instr_t    instr,
  output logic      out_valid,
  input  logic      out_ready,
  output reg_addr_t rd_addr,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output data_t     imm,
  output alu_op_t   alu_op,
  output lsu_op_t   lsu_op,
  output logic      rd_en,
  output logic      use_imm,
  output logic      ctl_alu,
  output logic      ctl_lsu,
  output logic      ctl_lui,
  output logic      ctl_auipc,
  output logic      ctl_br,
  output logic      ctl_jal,
  output logic      illegal
);

  alu_op_t  dec_alu_op;
  lsu_op_t  dec_lsu_op;
  imm_fmt_t dec_imm_fmt;
  data_t    dec_imm;
  logic     dec_rd_en;
  logic     dec_use_imm;
  logic     dec_alu;
  logic     dec_lsu;
  logic     dec_lui;
  logic     dec_auipc;
  logic     dec_br;
  logic     dec_jal;
  logic     dec_illegal;

  ctl_decode ctl0 (
    .instr    (instr),
    .alu_op   (dec_alu_op),
    .lsu_op   (dec_lsu_op),
    .imm_fmt  (dec_imm_fmt),
    .rd_en    (dec_rd_en),
    .use_imm  (dec_use_imm),
    .ctl_alu  (dec_alu),
    .ctl_lsu  (dec_lsu),
    .ctl_lui  (dec_lui),
    .ctl_auipc(dec_auipc),
    .ctl_br   (dec_br),
    .ctl_jal  (dec_jal),
    .illegal  (dec_illegal)
  );

  imm_gen imm0 (
    .instr  (instr),
    .imm_fmt(dec_imm_fmt),
    .imm    (dec_imm)
  );

  // Register fields come straight from the fixed RV32 bit positions
  decode_stage stage0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .rd_addr_in  (instr[11:7]),
    .rs1_addr_in (instr[19:15]),
    .rs2_addr_in (instr[24:20]),
    .imm_in      (dec_imm),
    .alu_op_in   (dec_alu_op),
    .lsu_op_in   (dec_lsu_op),
    .rd_en_in    (dec_rd_en),
    .use_imm_in  (dec_use_imm),
    .ctl_alu_in  (dec_alu),
    .ctl_lsu_in  (dec_lsu),
    .ctl_lui_in  (dec_lui),
    .ctl_auipc_in(dec_auipc),
    .ctl_br_in   (dec_br),
    .ctl_jal_in  (dec_jal),
    .illegal_in  (dec_illegal),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .rd_addr     (rd_addr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .lsu_op      (lsu_op),
    .rd_en       (rd_en),
    .use_imm     (use_imm),
    .ctl_alu     (ctl_alu),
    .ctl_lsu     (ctl_lsu),
    .ctl_lui     (ctl_lui),
    .ctl_auipc   (ctl_auipc),
    .ctl_br      (ctl_br),
    .ctl_jal     (ctl_jal),
    .illegal     (illegal)
  );

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock and reset
// 20 ns clock, arst_n held low for the first 4 cycles
module tb_clock (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // Released away from the active edge
  end

endmodule

// ==== verification/tb_riscv_decoder.sv ====
// Testbench for the RV32IM decoder
// Replays the stimulus file through the handshake and checks every decoded field
module tb_riscv_decoder import decode_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 200;
  localparam int MON_LIMIT  = 4000;

  typedef struct packed {
    instr_t    instr;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    alu_op_t   alu;
    lsu_op_t   lsu;
    logic [8:0] flags;  // rd_en use_imm alu lsu lui auipc br jal illegal
  } vec_t;

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  logic      in_ready;
  instr_t    instr;
  logic      out_valid;
  logic      out_ready;
  reg_addr_t rd_addr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     imm;
  alu_op_t   alu_op;
  lsu_op_t   lsu_op;
  logic      rd_en;
  logic      use_imm;
  logic      ctl_alu;
  logic      ctl_lsu;
  logic      ctl_lui;
  logic      ctl_auipc;
  logic      ctl_br;
  logic      ctl_jal;
  logic      illegal;

  vec_t        vecs[$];
  vec_t        exp_q[$];
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          timeouts = 0;
  int          consumed = 0;
  logic [31:0] rnd_drv = 32'h220e;
  logic [31:0] rnd_mon = 32'h220e;
  instr_t      cur_instr;

  tb_clock clock0 (.clk(clk), .arst_n(arst_n));

  riscv_decoder dut0 (
    .clk(clk), .arst_n(arst_n),
    .in_valid(in_valid), .in_ready(in_ready), .instr(instr),
    .out_valid(out_valid), .out_ready(out_ready),
    .rd_addr(rd_addr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .imm(imm), .alu_op(alu_op), .lsu_op(lsu_op),
    .rd_en(rd_en), .use_imm(use_imm), .ctl_alu(ctl_alu), .ctl_lsu(ctl_lsu),
    .ctl_lui(ctl_lui), .ctl_auipc(ctl_auipc), .ctl_br(ctl_br),
    .ctl_jal(ctl_jal), .illegal(illegal)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("FAIL %0t instr %h %s got %h expected %h", $time, cur_instr, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t instr %h %s got %h expected %h", $time, cur_instr, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_alu(string name, alu_op_t got, alu_op_t exp);
    if (got !== exp) begin
      $display("FAIL %0t instr %h %s got %h expected %h", $time, cur_instr, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_lsu(string name, lsu_op_t got, lsu_op_t exp);
    if (got !== exp) begin
      $display("FAIL %0t instr %h %s got %h expected %h", $time, cur_instr, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %0t instr %h %s got %b expected %b", $time, cur_instr, name, got, exp);
      value_errors++;
    end
  endtask

  function automatic vec_t capture_outputs();
    vec_t v;
    v.instr = '0;
    v.rd    = rd_addr;
    v.rs1   = rs1_addr;
    v.rs2   = rs2_addr;
    v.imm   = imm;
    v.alu   = alu_op;
    v.lsu   = lsu_op;
    v.flags = {rd_en, use_imm, ctl_alu, ctl_lsu, ctl_lui, ctl_auipc, ctl_br, ctl_jal, illegal};
    return v;
  endfunction

  task automatic compare_result(vec_t got, vec_t exp);
    cur_instr = exp.instr;
    check_reg("rd_addr", got.rd, exp.rd);
    check_reg("rs1_addr", got.rs1, exp.rs1);
    check_reg("rs2_addr", got.rs2, exp.rs2);
    check_data("imm", got.imm, exp.imm);
    check_alu("alu_op", got.alu, exp.alu);
    check_lsu("lsu_op", got.lsu, exp.lsu);
    check_flag("rd_en", got.flags[8], exp.flags[8]);
    check_flag("use_imm", got.flags[7], exp.flags[7]);
    check_flag("ctl_alu", got.flags[6], exp.flags[6]);
    check_flag("ctl_lsu", got.flags[5], exp.flags[5]);
    check_flag("ctl_lui", got.flags[4], exp.flags[4]);
    check_flag("ctl_auipc", got.flags[3], exp.flags[3]);
    check_flag("ctl_br", got.flags[2], exp.flags[2]);
    check_flag("ctl_jal", got.flags[1], exp.flags[1]);
    check_flag("illegal", got.flags[0], exp.flags[0]);
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] t_instr;
    logic [31:0] t_rd;
    logic [31:0] t_rs1;
    logic [31:0] t_rs2;
    logic [31:0] t_imm;
    logic [31:0] t_alu;
    logic [31:0] t_lsu;
    logic [31:0] t_flags;
    vec_t        v;
    fd = $fopen("verification/decode_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      protocol_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    t_instr, t_rd, t_rs1, t_rs2, t_imm, t_alu, t_lsu, t_flags);
        if (n != 8) begin
          $display("Malformed stimulus line: %s", line);
          protocol_errors++;
        end else begin
          v.instr = t_instr;
          v.rd    = reg_addr_t'(t_rd);
          v.rs1   = reg_addr_t'(t_rs1);
          v.rs2   = reg_addr_t'(t_rs2);
          v.imm   = t_imm;
          v.alu   = alu_op_t'(t_alu);
          v.lsu   = lsu_op_t'(t_lsu);
          v.flags = t_flags[8:0];
          vecs.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_driver();
    int gap;
    int waited;
    logic taken;
    for (int i = 0; i < vecs.size(); i++) begin
      rnd_drv = xorshift32(rnd_drv);
      gap = int'(rnd_drv[1:0]);
      for (int g = 0; g < gap; g++) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      @(negedge clk);
      in_valid = 1'b1;
      instr    = vecs[i].instr;
      waited = 0;
      taken  = 1'b0;
      while (!taken && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
        taken = in_ready;  // Value before the edge updates the stage
      end
      if (!taken) begin
        $display("Timeout: instruction %h was never accepted", vecs[i].instr);
        timeouts++;
        break;
      end
      exp_q.push_back(vecs[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    instr    = '0;
  endtask

  task automatic run_monitor();
    int   cycles;
    logic held;
    vec_t snap;
    vec_t got;
    vec_t exp;
    cycles = 0;
    held   = 1'b0;
    snap   = '0;
    while (consumed < vecs.size() && cycles < MON_LIMIT) begin
      @(negedge clk);
      cycles++;
      got = capture_outputs();
      if (held) begin
        if (!out_valid) begin
          $display("out_valid dropped at %0t while a result was held", $time);
          protocol_errors++;
        end else if (got != snap) begin
          $display("Held result changed under back-pressure at %0t", $time);
          protocol_errors++;
        end
      end
      rnd_mon   = xorshift32(rnd_mon);
      out_ready = rnd_mon[0] | rnd_mon[3];
      held = out_valid && !out_ready;
      snap = got;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Result at %0t has no pending instruction", $time);
          protocol_errors++;
        end else begin
          exp = exp_q.pop_front();
          compare_result(got, exp);
        end
        consumed++;
      end
    end
    if (consumed < vecs.size()) begin
      $display("Timeout: only %0d of %0d results came out", consumed, vecs.size());
      timeouts++;
    end
  endtask

  initial begin
    int waited;
    in_valid  = 1'b0;
    instr     = '0;
    out_ready = 1'b0;
    cur_instr = '0;
    load_stimulus();
    waited = 0;
    while (arst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end else if (vecs.size() == 0) begin
      $display("No stimulus lines were read");
      protocol_errors++;
    end else begin
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);  // Empty after reset
      check_flag("in_ready", in_ready, 1'b1);
      fork
        run_driver();
        run_monitor();
      join
      repeat (3) @(negedge clk);
      if (out_valid) begin
        $display("Extra result after all instructions were consumed");
        protocol_errors++;
      end
    end
    $display("Errors: value %0d, protocol %0d, timeout %0d, results %0d",
             value_errors, protocol_errors, timeouts, consumed);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/decode_stimulus.txt ====
# instr rd rs1 rs2 imm alu_op lsu_op flags, all hex
# flags msb first: rd_en use_imm alu lsu lui auipc br jal illegal
003100B3 01 02 03 00000000 00 0 140
407302B3 05 06 07 00000000 01 0 140
00A4F433 08 09 0A 00000000 02 0 140
00D665B3 0B 0C 0D 00000000 03 0 140
0107C733 0E 0F 10 00000000 04 0 140
003110B3 01 02 03 00000000 05 0 140
003150B3 01 02 03 00000000 06 0 140
403150B3 01 02 03 00000000 07 0 140
003120B3 01 02 03 00000000 08 0 140
003130B3 01 02 03 00000000 09 0 140
023100B3 01 02 03 00000000 0A 0 140
023110B3 01 02 03 00000000 0B 0 140
023120B3 01 02 03 00000000 0C 0 140
023130B3 01 02 03 00000000 0D 0 140
023140B3 01 02 03 00000000 0E 0 140
023150B3 01 02 03 00000000 0F 0 140
023160B3 01 02 03 00000000 10 0 140
023170B3 01 02 03 00000000 11 0 140
FFF10093 01 02 1F FFFFFFFF 00 0 1C0
00522193 03 04 05 00000005 08 0 1C0
7FF23193 03 04 1F 000007FF 09 0 1C0
80034293 05 06 00 FFFFF800 04 0 1C0
12336293 05 06 03 00000123 03 0 1C0
0F037293 05 06 10 000000F0 02 0 1C0
01F11093 01 02 1F 0000001F 05 0 1C0
00415093 01 02 04 00000004 06 0 1C0
40715093 01 02 07 00000007 07 0 1C0
40111093 01 02 01 00000000 00 0 001
FFC5A503 0A 0B 1C FFFFFFFC 00 5 120
00810083 01 02 08 00000008 00 1 120
00811083 01 02 08 00000008 00 3 120
00814083 01 02 08 00000008 00 2 120
00815083 01 02 08 00000008 00 4 120
FE532C23 18 06 05 FFFFFFF8 00 8 020
007401A3 03 08 07 00000003 00 6 020
04741023 00 08 07 00000040 00 7 020
00208863 10 01 02 00000010 00 0 084
FE209CE3 19 01 02 FFFFFFF8 00 0 084
0020D0E3 01 01 02 00000800 00 0 084
0020A063 00 01 02 00000000 00 0 001
001000EF 01 00 01 00000800 00 0 1C2
FFDFF06F 00 1F 1D FFFFFFFC 00 0 1C2
00C280E7 01 05 0C 0000000C 00 0 1C2
ABCDE137 02 1B 1C ABCDE000 00 0 1D0
12345197 03 08 03 12345000 00 0 1C8
0FF0000F 00 00 1F 00000000 00 0 0C0
0000100F 00 00 00 00000000 00 0 0C0
300110F3 01 02 00 00000000 00 0 001
00000073 00 00 00 00000000 00 0 001
043100B3 01 02 03 00000000 00 0 001
FFFFFFFF 1F 1F 1F 00000000 00 0 001

// ==== tb.f ====
source/decode_pkg.sv
source/ctl_decode.sv
source/imm_gen.sv
source/decode_stage.sv
source/riscv_decoder.sv
verification/tb_clock.sv
verification/tb_riscv_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_riscv_decoder \
  -f tb.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
